//--- common/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// datapath width
`define OOO_XLEN 32

// architectural registers x0..x31
`define OOO_NUM_REGS 32

// input queue depth, also the credits the producer starts with
`define OOO_IQ_DEPTH 4

// reservation station entries
`define OOO_RS_DEPTH 4

// reorder buffer entries, sets the tag width
`define OOO_ROB_DEPTH 8

// dispatch to cdb latency
`define OOO_ALU_STAGES 2

`endif

//--- common/ooo_isa_pkg.sv
`default_nettype none

package ooo_isa_pkg;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OPIMM = 7'b0010011,
    OPC_OP    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12; // sign extended, low 5 bits are shamt for shifts
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // one instruction word, two decodings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

endpackage

`default_nettype wire

//--- common/ooo_core_pkg.sv
`default_nettype none
`include "ooo_macros.svh"

package ooo_core_pkg;

  // tag = rob slot index
  localparam int ROB_TAG_W = $clog2(`OOO_ROB_DEPTH);

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // rob tag, carried on the cdb and in the rename table
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // data word of the register file, operands and cdb
  typedef logic [`OOO_XLEN-1:0] word_t;

endpackage

`default_nettype wire

//--- design/alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_macros.svh"

module alu_pipe
  import ooo_core_pkg::*;
  import ooo_isa_pkg::*;
(
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_disp_valid,
  input wire [3:0] i_disp_op,
  input wire word_t i_disp_a,
  input wire word_t i_disp_b,
  input wire rob_tag_t i_disp_tag,
  output logic o_cdb_valid,
  output rob_tag_t o_cdb_tag,
  output word_t o_cdb_value
);
  localparam int STAGES = `OOO_ALU_STAGES;

  logic [STAGES-1:0] vld_pipe;
  rob_tag_t tag_pipe [STAGES];
  alu_op_e s1_op;
  word_t s1_a;
  word_t s1_b;
  word_t alu_result;

  // valid and tag ride alongside the data
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[STAGES-2:0], i_disp_valid};
    end
  end

  always_ff @(posedge clk_100mhz) begin
    tag_pipe[0] <= i_disp_tag;
    for (int k = 1; k < STAGES; k++) begin
      tag_pipe[k] <= tag_pipe[k-1];
    end
  end

  // stage one, operand register
  always_ff @(posedge clk_100mhz) begin
    s1_op <= alu_op_e'(i_disp_op);
    s1_a <= i_disp_a;
    s1_b <= i_disp_b;
  end

  always_comb begin
    case (s1_op)
      ALU_ADD: alu_result = s1_a + s1_b;
      ALU_SUB: alu_result = s1_a - s1_b;
      ALU_SLL: alu_result = s1_a << s1_b[4:0];
      ALU_SLT: alu_result = word_t'($signed(s1_a) < $signed(s1_b));
      ALU_SLTU: alu_result = word_t'(s1_a < s1_b);
      ALU_XOR: alu_result = s1_a ^ s1_b;
      ALU_SRL: alu_result = s1_a >> s1_b[4:0];
      ALU_SRA: alu_result = word_t'($signed(s1_a) >>> s1_b[4:0]);
      ALU_OR: alu_result = s1_a | s1_b;
      ALU_AND: alu_result = s1_a & s1_b;
      default: alu_result = '0;
    endcase
  end

  // stage two, result onto the cdb
  always_ff @(posedge clk_100mhz) begin
    o_cdb_value <= alu_result;
  end

  assign o_cdb_valid = vld_pipe[STAGES-1];
  assign o_cdb_tag = tag_pipe[STAGES-1];

endmodule

`default_nettype wire

//--- rob/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_macros.svh"

module reorder_buffer
  import ooo_core_pkg::*;
(
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_alloc_valid,
  input wire reg_idx_t i_alloc_rd,
  input wire i_cdb_valid,
  input wire rob_tag_t i_cdb_tag,
  input wire word_t i_cdb_value,
  input wire rob_tag_t i_look1_tag,
  input wire rob_tag_t i_look2_tag,
  output rob_tag_t o_rob_tail,
  output logic o_rob_credit,
  output logic o_look1_done,
  output word_t o_look1_value,
  output logic o_look2_done,
  output word_t o_look2_value,
  output logic o_commit_valid,
  output reg_idx_t o_commit_rd,
  output word_t o_commit_value,
  output rob_tag_t o_commit_tag
);
  localparam int DEPTH = `OOO_ROB_DEPTH;

  rob_tag_t head; // oldest in flight
  rob_tag_t tail; // next slot to allocate
  logic [DEPTH-1:0] ent_valid;
  logic [DEPTH-1:0] ent_done;
  reg_idx_t ent_rd [DEPTH];
  word_t ent_value [DEPTH];
  logic commit;

  function automatic rob_tag_t next_ptr(input rob_tag_t ptr);
    return (ptr == rob_tag_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign commit = ent_valid[head] && ent_done[head];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head <= '0;
      tail <= '0;
      ent_valid <= '0;
      ent_done <= '0;
    end else begin
      if (i_alloc_valid) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail] <= 1'b0;
        tail <= next_ptr(tail);
      end
      if (i_cdb_valid) ent_done[i_cdb_tag] <= 1'b1;
      if (commit) begin
        ent_valid[head] <= 1'b0;
        head <= next_ptr(head);
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc_valid) ent_rd[tail] <= i_alloc_rd;
    if (i_cdb_valid) ent_value[i_cdb_tag] <= i_cdb_value;
  end

  // operand lookup for decode
  assign o_look1_done = ent_valid[i_look1_tag] && ent_done[i_look1_tag];
  assign o_look1_value = ent_value[i_look1_tag];
  assign o_look2_done = ent_valid[i_look2_tag] && ent_done[i_look2_tag];
  assign o_look2_value = ent_value[i_look2_tag];

  assign o_rob_tail = tail;
  assign o_rob_credit = commit;
  assign o_commit_valid = commit;
  assign o_commit_rd = ent_rd[head];
  assign o_commit_value = (ent_rd[head] == '0) ? '0 : ent_value[head]; // x0 stays zero
  assign o_commit_tag = head;

endmodule

`default_nettype wire

//--- rs/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_macros.svh"

module reservation_station
  import ooo_core_pkg::*;
(
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_issue_valid,
  input wire [3:0] i_issue_op,
  input wire word_t i_issue_v1,
  input wire word_t i_issue_v2,
  input wire i_issue_rdy1,
  input wire i_issue_rdy2,
  input wire rob_tag_t i_issue_q1,
  input wire rob_tag_t i_issue_q2,
  input wire rob_tag_t i_issue_tag,
  input wire i_cdb_valid,
  input wire rob_tag_t i_cdb_tag,
  input wire word_t i_cdb_value,
  output logic o_rs_credit,
  output logic o_disp_valid,
  output logic [3:0] o_disp_op,
  output word_t o_disp_a,
  output word_t o_disp_b,
  output rob_tag_t o_disp_tag
);
  localparam int DEPTH = `OOO_RS_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);

  logic [DEPTH-1:0] ent_valid;
  logic [DEPTH-1:0] ent_rdy1;
  logic [DEPTH-1:0] ent_rdy2;
  logic [3:0] ent_op [DEPTH];
  word_t ent_v1 [DEPTH];
  word_t ent_v2 [DEPTH];
  rob_tag_t ent_q1 [DEPTH];
  rob_tag_t ent_q2 [DEPTH];
  rob_tag_t ent_tag [DEPTH];
  logic [IDX_W-1:0] ent_age [DEPTH]; // 0 is oldest, ranks stay dense

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W:0] occupancy;
  logic [IDX_W-1:0] new_age;
  logic [IDX_W-1:0] sel_idx;
  logic sel_found;

  // lowest free slot, credits guarantee one exists on issue
  always_comb begin
    free_idx = '0;
    occupancy = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx = IDX_W'(i);
      end else begin
        occupancy = occupancy + 1'b1;
      end
    end
  end

  // oldest entry with both operands in hand
  always_comb begin
    sel_found = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (ent_valid[i] && ent_rdy1[i] && ent_rdy2[i] &&
          (!sel_found || ent_age[i] < ent_age[sel_idx])) begin
        sel_found = 1'b1;
        sel_idx = IDX_W'(i);
      end
    end
  end

  // new entry ranks behind everything that stays
  assign new_age = IDX_W'(occupancy - {{IDX_W{1'b0}}, sel_found});

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      ent_valid <= '0;
      ent_rdy1 <= '0;
      ent_rdy2 <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (i_cdb_valid && ent_valid[i] && !ent_rdy1[i] && ent_q1[i] == i_cdb_tag) begin
          ent_rdy1[i] <= 1'b1;
        end
        if (i_cdb_valid && ent_valid[i] && !ent_rdy2[i] && ent_q2[i] == i_cdb_tag) begin
          ent_rdy2[i] <= 1'b1;
        end
      end
      if (sel_found) ent_valid[sel_idx] <= 1'b0;
      if (i_issue_valid) begin
        ent_valid[free_idx] <= 1'b1;
        ent_rdy1[free_idx] <= i_issue_rdy1;
        ent_rdy2[free_idx] <= i_issue_rdy2;
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (i_cdb_valid && !ent_rdy1[i] && ent_q1[i] == i_cdb_tag) ent_v1[i] <= i_cdb_value;
      if (i_cdb_valid && !ent_rdy2[i] && ent_q2[i] == i_cdb_tag) ent_v2[i] <= i_cdb_value;
      // close the gap left by the dispatched entry
      if (sel_found && ent_valid[i] && ent_age[i] > ent_age[sel_idx]) begin
        ent_age[i] <= ent_age[i] - 1'b1;
      end
    end
    if (i_issue_valid) begin
      ent_op[free_idx] <= i_issue_op;
      ent_v1[free_idx] <= i_issue_v1;
      ent_v2[free_idx] <= i_issue_v2;
      ent_q1[free_idx] <= i_issue_q1;
      ent_q2[free_idx] <= i_issue_q2;
      ent_tag[free_idx] <= i_issue_tag;
      ent_age[free_idx] <= new_age;
    end
  end

  assign o_disp_valid = sel_found;
  assign o_rs_credit = sel_found; // slot frees at this edge
  assign o_disp_op = ent_op[sel_idx];
  assign o_disp_a = ent_v1[sel_idx];
  assign o_disp_b = ent_v2[sel_idx];
  assign o_disp_tag = ent_tag[sel_idx];

endmodule

`default_nettype wire

//--- design/decode_rename.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_macros.svh"

module decode_rename
  import ooo_core_pkg::*;
  import ooo_isa_pkg::*;
(
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_inst_valid,
  input wire word_t i_inst,
  input wire i_rs_credit,
  input wire i_rob_credit,
  input wire rob_tag_t i_rob_tail,
  input wire i_look1_done,
  input wire word_t i_look1_value,
  input wire i_look2_done,
  input wire word_t i_look2_value,
  input wire i_cdb_valid,
  input wire rob_tag_t i_cdb_tag,
  input wire word_t i_cdb_value,
  input wire i_commit_valid,
  input wire reg_idx_t i_commit_rd,
  input wire word_t i_commit_value,
  input wire rob_tag_t i_commit_tag,
  output logic o_inst_credit,
  output logic o_issue_valid,
  output alu_op_e o_issue_op,
  output word_t o_issue_v1,
  output word_t o_issue_v2,
  output logic o_issue_rdy1,
  output logic o_issue_rdy2,
  output rob_tag_t o_issue_q1,
  output rob_tag_t o_issue_q2,
  output rob_tag_t o_issue_tag,
  output logic o_alloc_valid,
  output reg_idx_t o_alloc_rd,
  output rob_tag_t o_look1_tag,
  output rob_tag_t o_look2_tag
);
  localparam int IQ_PTR_W = $clog2(`OOO_IQ_DEPTH);
  localparam int IQ_CNT_W = $clog2(`OOO_IQ_DEPTH + 1);
  localparam int RS_CNT_W = $clog2(`OOO_RS_DEPTH + 1);
  localparam int ROB_CNT_W = $clog2(`OOO_ROB_DEPTH + 1);

  word_t iq_mem [`OOO_IQ_DEPTH];
  logic [IQ_PTR_W-1:0] iq_wr_ptr;
  logic [IQ_PTR_W-1:0] iq_rd_ptr;
  logic [IQ_CNT_W-1:0] iq_count;
  logic [RS_CNT_W-1:0] rs_credits;
  logic [ROB_CNT_W-1:0] rob_credits;
  logic issue;

  inst_u head;
  logic is_imm;
  alu_op_e op;
  word_t imm;

  word_t regs [`OOO_NUM_REGS];
  logic [`OOO_NUM_REGS-1:0] busy; // a rob entry will write this reg
  rob_tag_t rename_tag [`OOO_NUM_REGS];

  // one instruction per cycle, only with room downstream in both rs and rob
  assign issue = (iq_count != '0) && (rs_credits != '0) && (rob_credits != '0);

  always_ff @(posedge clk_100mhz) begin
    if (i_inst_valid) begin
      iq_mem[iq_wr_ptr] <= i_inst;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      iq_wr_ptr <= '0;
      iq_rd_ptr <= '0;
      iq_count <= '0;
      rs_credits <= RS_CNT_W'(`OOO_RS_DEPTH);
      rob_credits <= ROB_CNT_W'(`OOO_ROB_DEPTH);
    end else begin
      if (i_inst_valid) iq_wr_ptr <= iq_wr_ptr + 1'b1; // producer never overruns, credits
      if (issue) iq_rd_ptr <= iq_rd_ptr + 1'b1;
      iq_count <= iq_count + IQ_CNT_W'(i_inst_valid) - IQ_CNT_W'(issue);
      rs_credits <= rs_credits - RS_CNT_W'(issue) + RS_CNT_W'(i_rs_credit);
      rob_credits <= rob_credits - ROB_CNT_W'(issue) + ROB_CNT_W'(i_rob_credit);
    end
  end

  // decode of the queue head
  assign head = iq_mem[iq_rd_ptr];
  assign is_imm = (head.i.opcode == OPC_OPIMM);
  assign imm = word_t'($signed(head.i.imm12));

  always_comb begin
    case (head.r.funct3)
      3'b000: op = (!is_imm && head.r.funct7[5]) ? ALU_SUB : ALU_ADD; // no subi
      3'b001: op = ALU_SLL;
      3'b010: op = ALU_SLT;
      3'b011: op = ALU_SLTU;
      3'b100: op = ALU_XOR;
      3'b101: op = head.r.funct7[5] ? ALU_SRA : ALU_SRL; // imm12[10] for srai
      3'b110: op = ALU_OR;
      default: op = ALU_AND;
    endcase
  end

  // operand source: regfile, done rob entry, or result on the bus right now
  function automatic logic resolve_src(input reg_idx_t src, input logic look_done,
                                       input word_t look_value, output word_t value);
    logic rdy;
    rdy = 1'b1;
    value = '0;
    if (src == '0) begin
      value = '0;
    end else if (!busy[src]) begin
      value = regs[src];
    end else if (look_done) begin
      value = look_value;
    end else if (i_cdb_valid && i_cdb_tag == rename_tag[src]) begin
      value = i_cdb_value;
    end else begin
      rdy = 1'b0; // wait in rs for the tag
    end
    return rdy;
  endfunction

  always_comb begin
    o_issue_rdy1 = resolve_src(head.r.rs1, i_look1_done, i_look1_value, o_issue_v1);
    if (is_imm) begin
      o_issue_v2 = imm;
      o_issue_rdy2 = 1'b1;
    end else begin
      o_issue_rdy2 = resolve_src(head.r.rs2, i_look2_done, i_look2_value, o_issue_v2);
    end
  end

  assign o_look1_tag = rename_tag[head.r.rs1];
  assign o_look2_tag = rename_tag[head.r.rs2];
  assign o_issue_q1 = rename_tag[head.r.rs1];
  assign o_issue_q2 = rename_tag[head.r.rs2];
  assign o_issue_tag = i_rob_tail; // rob allocates at its tail
  assign o_issue_op = op;
  assign o_issue_valid = issue;
  assign o_alloc_valid = issue;
  assign o_alloc_rd = head.r.rd;
  assign o_inst_credit = issue; // queue slot freed

  // register file and busy bits
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int r = 0; r < `OOO_NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (i_commit_valid && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        // newer producer keeps the reg busy
        if (rename_tag[i_commit_rd] == i_commit_tag) busy[i_commit_rd] <= 1'b0;
      end
      if (issue && head.r.rd != '0) busy[head.r.rd] <= 1'b1; // wins over commit clear
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (issue) begin
      rename_tag[head.r.rd] <= i_rob_tail;
    end
  end

endmodule

`default_nettype wire

//--- design/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core
  import ooo_core_pkg::*;
(
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_inst_valid,
  input wire word_t i_inst,
  output logic o_inst_credit,
  output logic o_commit_valid,
  output reg_idx_t o_commit_rd,
  output word_t o_commit_value
);
  // decode to rs
  logic issue_valid;
  logic [3:0] issue_op;
  word_t issue_v1;
  word_t issue_v2;
  logic issue_rdy1;
  logic issue_rdy2;
  rob_tag_t issue_q1;
  rob_tag_t issue_q2;
  rob_tag_t issue_tag;
  logic rs_credit;

  // decode to rob
  logic alloc_valid;
  reg_idx_t alloc_rd;
  logic rob_credit;
  rob_tag_t rob_tail;
  rob_tag_t look1_tag;
  rob_tag_t look2_tag;
  logic look1_done;
  logic look2_done;
  word_t look1_value;
  word_t look2_value;
  rob_tag_t commit_tag;

  // rs to alu
  logic disp_valid;
  logic [3:0] disp_op;
  word_t disp_a;
  word_t disp_b;
  rob_tag_t disp_tag;

  // common data bus
  logic cdb_valid;
  rob_tag_t cdb_tag;
  word_t cdb_value;

  decode_rename decode0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid),
    .i_inst(i_inst),
    .i_rs_credit(rs_credit),
    .i_rob_credit(rob_credit),
    .i_rob_tail(rob_tail),
    .i_look1_done(look1_done),
    .i_look1_value(look1_value),
    .i_look2_done(look2_done),
    .i_look2_value(look2_value),
    .i_cdb_valid(cdb_valid),
    .i_cdb_tag(cdb_tag),
    .i_cdb_value(cdb_value),
    .i_commit_valid(o_commit_valid),
    .i_commit_rd(o_commit_rd),
    .i_commit_value(o_commit_value),
    .i_commit_tag(commit_tag),
    .o_inst_credit(o_inst_credit),
    .o_issue_valid(issue_valid),
    .o_issue_op(issue_op),
    .o_issue_v1(issue_v1),
    .o_issue_v2(issue_v2),
    .o_issue_rdy1(issue_rdy1),
    .o_issue_rdy2(issue_rdy2),
    .o_issue_q1(issue_q1),
    .o_issue_q2(issue_q2),
    .o_issue_tag(issue_tag),
    .o_alloc_valid(alloc_valid),
    .o_alloc_rd(alloc_rd),
    .o_look1_tag(look1_tag),
    .o_look2_tag(look2_tag)
  );

  reservation_station rs0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_issue_valid(issue_valid),
    .i_issue_op(issue_op),
    .i_issue_v1(issue_v1),
    .i_issue_v2(issue_v2),
    .i_issue_rdy1(issue_rdy1),
    .i_issue_rdy2(issue_rdy2),
    .i_issue_q1(issue_q1),
    .i_issue_q2(issue_q2),
    .i_issue_tag(issue_tag),
    .i_cdb_valid(cdb_valid),
    .i_cdb_tag(cdb_tag),
    .i_cdb_value(cdb_value),
    .o_rs_credit(rs_credit),
    .o_disp_valid(disp_valid),
    .o_disp_op(disp_op),
    .o_disp_a(disp_a),
    .o_disp_b(disp_b),
    .o_disp_tag(disp_tag)
  );

  alu_pipe alu0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_disp_valid(disp_valid),
    .i_disp_op(disp_op),
    .i_disp_a(disp_a),
    .i_disp_b(disp_b),
    .i_disp_tag(disp_tag),
    .o_cdb_valid(cdb_valid),
    .o_cdb_tag(cdb_tag),
    .o_cdb_value(cdb_value)
  );

  reorder_buffer rob0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_alloc_valid(alloc_valid),
    .i_alloc_rd(alloc_rd),
    .i_cdb_valid(cdb_valid),
    .i_cdb_tag(cdb_tag),
    .i_cdb_value(cdb_value),
    .i_look1_tag(look1_tag),
    .i_look2_tag(look2_tag),
    .o_rob_tail(rob_tail),
    .o_rob_credit(rob_credit),
    .o_look1_done(look1_done),
    .o_look1_value(look1_value),
    .o_look2_done(look2_done),
    .o_look2_value(look2_value),
    .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value),
    .o_commit_tag(commit_tag)
  );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int RST_CYCLES = 16
) (
  output logic clk_100mhz,
  output logic sys_rst
);
  // 10 ns period
  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_100mhz);
    sys_rst <= 1'b0; // released just after the last reset edge
  end

endmodule

`default_nettype wire

//--- verification/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "ooo_macros.svh"

module tb_ooo_core
  import ooo_core_pkg::*;
  import ooo_isa_pkg::*;
();
  localparam int NUM_INST = 2000;
  localparam int DENSE_RUN = 250; // alternating full range and x1..x4 blocks
  localparam int MAX_CYCLES = 40 * NUM_INST + 100;
  localparam int DRAIN_CYCLES = 20;

  logic clk_100mhz;
  logic sys_rst;
  logic i_inst_valid;
  word_t i_inst;
  logic o_inst_credit;
  logic o_commit_valid;
  reg_idx_t o_commit_rd;
  word_t o_commit_value;

  logic [31:0] rng_state;
  logic [31:0] model_regs [32]; // in-order architectural state
  logic [4:0] exp_rd_q [$];
  logic [31:0] exp_value_q [$];
  int credits;
  int sent;
  int returned;
  int commits;
  int cycles;
  int drain;

  clock_gen #(.RST_CYCLES(16)) clkgen0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst)
  );

  ooo_core dut0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .i_inst_valid(i_inst_valid),
    .i_inst(i_inst),
    .o_inst_credit(o_inst_credit),
    .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd),
    .o_commit_value(o_commit_value)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // x0 now and then, otherwise x1..x4 or any register
  function automatic logic [4:0] pick_reg(input logic dense);
    logic [31:0] r;
    r = next_random();
    if (r[3:0] == 4'd0) return 5'd0;
    if (dense) return 5'd1 + {3'b000, r[9:8]};
    return r[12:8];
  endfunction

  function automatic logic [31:0] make_instruction(input logic dense);
    logic [31:0] r;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    r = next_random();
    rd = pick_reg(dense);
    rs1 = pick_reg(dense);
    rs2 = pick_reg(dense);
    f3 = r[3:1];
    if (r[0]) begin
      case (f3)
        3'b001: imm = {7'b0000000, r[9:5]};
        3'b101: imm = {1'b0, r[4], 5'b00000, r[9:5]}; // srai when bit 10 set
        default: imm = r[31:20];
      endcase
      return {imm, rs1, f3, rd, OPC_OPIMM};
    end
    f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[4]) ? 7'h20 : 7'h00;
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  // rv32i result against the in-order register state
  function automatic logic [31:0] model_execute(input logic [31:0] word);
    inst_u w;
    logic is_imm;
    logic alt;
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0] sh;
    logic [31:0] res;
    w = word;
    is_imm = (w.i.opcode == OPC_OPIMM);
    a = model_regs[w.r.rs1];
    b = is_imm ? {{20{w.i.imm12[11]}}, w.i.imm12} : model_regs[w.r.rs2];
    alt = w.r.funct7[5]; // imm bit 10 for the I form
    sh = b[4:0];
    case (w.r.funct3)
      3'b000: res = (alt && !is_imm) ? a - b : a + b;
      3'b001: res = a << sh;
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: res = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic send_instruction();
    logic [31:0] word;
    logic [4:0] rd;
    logic [31:0] value;
    word = make_instruction((sent / DENSE_RUN) % 2 == 1);
    rd = word[11:7];
    value = model_execute(word);
    if (rd != 5'd0) model_regs[rd] = value;
    exp_rd_q.push_back(rd);
    exp_value_q.push_back((rd == 5'd0) ? 32'd0 : value);
    i_inst = word;
    i_inst_valid = 1'b1;
    credits--;
    sent++;
  endtask

  task automatic check_commit();
    logic [4:0] rd;
    logic [31:0] value;
    if (exp_rd_q.size() == 0) begin
      fail_run($sformatf("a commit to x%0d arrived with no instruction outstanding",
                         o_commit_rd));
    end else begin
      rd = exp_rd_q.pop_front();
      value = exp_value_q.pop_front();
      check_equal($sformatf("commit %0d rd", commits), {27'b0, rd}, {27'b0, o_commit_rd});
      check_equal($sformatf("commit %0d value", commits), value, o_commit_value);
      commits++;
    end
  endtask

  initial begin
    rng_state = 32'hdd83ba49;
    i_inst_valid = 1'b0;
    i_inst = '0;
    credits = `OOO_IQ_DEPTH;
    sent = 0;
    returned = 0;
    commits = 0;
    cycles = 0;
    drain = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end

    // outputs quiet through reset and the first cycle after it
    @(negedge clk_100mhz);
    while (sys_rst) begin
      check_equal("reset o_inst_credit", 32'd0, {31'b0, o_inst_credit});
      check_equal("reset o_commit_valid", 32'd0, {31'b0, o_commit_valid});
      @(negedge clk_100mhz);
    end
    check_equal("post reset o_inst_credit", 32'd0, {31'b0, o_inst_credit});
    check_equal("post reset o_commit_valid", 32'd0, {31'b0, o_commit_valid});

    while (commits < NUM_INST || drain < DRAIN_CYCLES) begin
      @(negedge clk_100mhz);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        fail_run($sformatf("timeout after %0d cycles, only %0d of %0d instructions committed",
                           cycles, commits, NUM_INST));
      end
      if (o_inst_credit) begin
        if (credits >= `OOO_IQ_DEPTH) begin
          fail_run("an input credit came back with no instruction outstanding");
        end
        credits++;
        returned++;
      end
      if (o_commit_valid) check_commit();
      i_inst_valid = 1'b0;
      if (sent < NUM_INST && credits > 0 && next_random() % 4 != 0) begin
        send_instruction();
      end
      if (commits == NUM_INST) drain++;
    end

    if (returned == sent) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run($sformatf("%0d instructions sent but %0d input credits returned",
                         sent, returned));
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/ooo_isa_pkg.sv
common/ooo_core_pkg.sv
design/alu_pipe.sv
rob/reorder_buffer.sv
rs/reservation_station.sv
design/decode_rename.sv
design/ooo_core.sv
verification/clock_gen.sv
verification/tb_ooo_core.sv

//--- Makefile
# Verilator build and run for the out-of-order core testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard common/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
